// ==== Bender.yml ====
package:
  name: memSubsystem

sources:
  - cpuMemPkg.sv
  - memCtrl.sv
  - fetchUnit.sv
  - instQueue.sv
  - memSubsystem.sv
  - target: simulation
    files:
      - memChecker.sv
      - tbMemSubsystem.sv

// ==== build.f ====
cpuMemPkg.sv
memCtrl.sv
fetchUnit.sv
instQueue.sv
memSubsystem.sv
memChecker.sv
tbMemSubsystem.sv

// ==== cpuMemPkg.sv ====
package cpuMemPkg;

    localparam int ADDR_WIDTH = 32;
    localparam int XLEN = 32;
    localparam int BYTE_WIDTH = 8;

    // one instruction per fetch
    localparam int PC_STEP = 4;

    localparam int QUEUE_DEPTH = 4;

    typedef enum logic {
        opLoad,
        opStore
    } memOp_e;

    typedef enum logic [1:0] {
        stIdle,
        stFetch,
        stLoad,
        stStore
    } ctrlState_e;

    // len is 1, 2 or 4 bytes
    typedef struct packed {
        memOp_e                op;
        logic [2:0]            len;
        logic [ADDR_WIDTH-1:0] addr;
        logic [XLEN-1:0]       wdata;
    } dataReq_t;

    typedef struct packed {
        logic                  we;
        logic [ADDR_WIDTH-1:0] addr;
        logic [BYTE_WIDTH-1:0] wdata;
    } memPort_t;

    typedef struct packed {
        logic [ADDR_WIDTH-1:0] pc;
        logic [XLEN-1:0]       inst;
    } fetchEntry_t;

endpackage

// ==== fetchUnit.sv ====
module fetchUnit (
    input  logic                                clk,
    input  logic                                rst,
    input  logic                                rdy,
    input  logic                                fetchDone,
    input  logic [cpuMemPkg::XLEN-1:0]          fetchInst,
    input  logic [2:0]                          queueFree,
    output logic                                fetchEn,
    output logic [cpuMemPkg::ADDR_WIDTH-1:0]    fetchAddr,
    output logic                                pushValid,
    output cpuMemPkg::fetchEntry_t              pushEntry
);

    logic [cpuMemPkg::ADDR_WIDTH-1:0] pc;

    assign fetchAddr = pc;

    // completed word goes straight into the queue
    assign pushValid = fetchDone;
    assign pushEntry.pc = pc;
    assign pushEntry.inst = fetchInst;

    always_ff @(posedge clk) begin
        if (rst) begin
            pc <= '0;
        end else if (rdy && fetchDone) begin
            pc <= pc + cpuMemPkg::ADDR_WIDTH'(cpuMemPkg::PC_STEP);
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            fetchEn <= 1'b0;
        end else if (rdy) begin
            if (fetchEn) begin
                // queueFree does not count the entry pushed this cycle yet
                if (fetchDone) begin
                    fetchEn <= (queueFree > 3'd1);
                end
            end else begin
                fetchEn <= (queueFree != 3'd0);
            end
        end
    end

endmodule

// ==== instQueue.sv ====
module instQueue (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        rdy,
    input  logic                        pushValid,
    input  cpuMemPkg::fetchEntry_t      pushEntry,
    input  logic                        popReady,
    output logic                        popValid,
    output cpuMemPkg::fetchEntry_t      popEntry,
    output logic [2:0]                  queueFree
);

    cpuMemPkg::fetchEntry_t entries [cpuMemPkg::QUEUE_DEPTH];

    logic [$clog2(cpuMemPkg::QUEUE_DEPTH)-1:0] wrPtr;
    logic [$clog2(cpuMemPkg::QUEUE_DEPTH)-1:0] rdPtr;
    logic [2:0] count;
    logic push;
    logic pop;

    assign push = pushValid && rdy;
    assign pop = popValid && popReady;

    // nothing leaves while frozen
    assign popValid = rdy && (count != 3'd0);
    assign popEntry = entries[rdPtr];
    assign queueFree = 3'(cpuMemPkg::QUEUE_DEPTH) - count;

    always_ff @(posedge clk) begin
        if (push) begin
            entries[wrPtr] <= pushEntry;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wrPtr <= '0;
            rdPtr <= '0;
            count <= '0;
        end else if (rdy) begin
            if (push) begin
                wrPtr <= wrPtr + 1'b1;
            end
            if (pop) begin
                rdPtr <= rdPtr + 1'b1;
            end
            // simultaneous push and pop leaves count alone
            if (push && !pop) begin
                count <= count + 3'd1;
            end else if (pop && !push) begin
                count <= count - 3'd1;
            end
        end
    end

endmodule

// ==== memChecker.sv ====
module memChecker (
    input logic                     clk,
    input logic                     rst,
    input logic                     rdy,
    input logic                     ioBufferFull,
    input logic                     dataEn,
    input cpuMemPkg::dataReq_t      dataReq,
    input logic                     dataDone,
    input logic [31:0]              dataRdata,
    input cpuMemPkg::memPort_t      ramCmd,
    input logic                     popValid,
    input logic                     popReady,
    input cpuMemPkg::fetchEntry_t   popEntry,
    input logic                     pushValid,
    input cpuMemPkg::ctrlState_e    ctrlState
);
    timeunit 1ns;
    timeprecision 1ps;

    logic [7:0] shadow [256];
    int errors = 0;
    int tests = 0;
    int popCount = 0;
    int depth = 0;
    int lat = 0;
    int wrCount = 0;
    bit busy = 0;
    logic [31:0] nextPc = 0;

    initial begin
        #1;
        for (int i = 0; i < 256; i++) begin
            shadow[i] = tbMemSubsystem.ram[i];
        end
    end

    // little-endian, zero-extended
    function automatic logic [31:0] readShadow(logic [31:0] addr, int len);
        logic [31:0] v;
        v = '0;
        for (int k = 0; k < len; k++) begin
            v[8*k +: 8] = shadow[8'(addr + k)];
        end
        return v;
    endfunction

    task automatic fail(string msg);
        errors++;
        $display("error %0t: %s", $time, msg);
    endtask

    task report();
        $display("%0d data tests, %0d pops, %0d errors", tests, popCount, errors);
    endtask

    always @(posedge clk) begin
        int off;
        bit ok;
        if (!rst) begin
            if (!(rdy && !ioBufferFull) && (ramCmd.we || dataDone)) begin
                fail("write or dataDone during a stall");
            end
            if (ramCmd.we) begin
                off = int'(ramCmd.addr - dataReq.addr);
                // bytes go out one by one from addr upward
                if (!dataEn || dataReq.op != cpuMemPkg::opStore || off != wrCount ||
                    wrCount >= dataReq.len ||
                    ramCmd.wdata != dataReq.wdata[8*off +: 8]) begin
                    fail($sformatf("bad write %h to %h", ramCmd.wdata, ramCmd.addr));
                end
                wrCount++;
                shadow[ramCmd.addr[7:0]] = ramCmd.wdata;
            end
            if (rdy && !ioBufferFull) begin
                if (busy) begin
                    lat++;
                end else if (dataEn && ctrlState == cpuMemPkg::stIdle) begin
                    // acceptance is the first counted cycle
                    busy = 1;
                    lat = 1;
                end
            end
            if (dataDone) begin
                ok = 1;
                busy = 0;
                tests++;
                if (dataReq.op == cpuMemPkg::opLoad) begin
                    if (dataRdata != readShadow(dataReq.addr, dataReq.len)) begin
                        fail($sformatf("load %h got %h", dataReq.addr, dataRdata));
                        ok = 0;
                    end
                    if (lat != dataReq.len + 1) begin
                        fail($sformatf("load latency %0d for len %0d", lat, dataReq.len));
                        ok = 0;
                    end
                end else if (wrCount != dataReq.len) begin
                    fail($sformatf("store wrote %0d bytes for len %0d", wrCount, dataReq.len));
                    ok = 0;
                end
                wrCount = 0;
                if (ok) begin
                    $display("test %0d %s len %0d at %h ok", tests,
                             dataReq.op == cpuMemPkg::opLoad ? "load" : "store",
                             dataReq.len, dataReq.addr);
                end
            end
            if (pushValid && rdy) begin
                depth++;
            end
            if (popValid && popReady) begin
                depth--;
                popCount++;
                if (popEntry.pc != nextPc || popEntry.inst != readShadow(popEntry.pc, 4)) begin
                    fail($sformatf("pop pc %h inst %h", popEntry.pc, popEntry.inst));
                end
                nextPc = nextPc + cpuMemPkg::PC_STEP;
            end
            if (depth > cpuMemPkg::QUEUE_DEPTH) begin
                fail("queue holds more than its depth");
            end
        end
    end

endmodule

// ==== memCtrl.sv ====
module memCtrl (
    input  logic                                clk,
    input  logic                                rst,
    input  logic                                rdy,
    input  logic                                ioBufferFull,
    input  logic                                dataEn,
    input  cpuMemPkg::dataReq_t                 dataReq,
    input  logic                                fetchEn,
    input  logic [cpuMemPkg::ADDR_WIDTH-1:0]    fetchAddr,
    input  logic [cpuMemPkg::BYTE_WIDTH-1:0]    ramRdata,
    output cpuMemPkg::memPort_t                 ramCmd,
    output logic                                dataDone,
    output logic [cpuMemPkg::XLEN-1:0]          dataRdata,
    output logic                                fetchDone,
    output logic [cpuMemPkg::XLEN-1:0]          fetchInst
);

    cpuMemPkg::ctrlState_e state;
    logic [2:0] stage;
    logic active;

    // request latched at acceptance
    cpuMemPkg::dataReq_t req;

    logic [cpuMemPkg::XLEN-1:0] shiftWord;
    logic [cpuMemPkg::XLEN-1:0] assembled;
    logic [cpuMemPkg::ADDR_WIDTH-1:0] lastAddr;
    logic [cpuMemPkg::ADDR_WIDTH-1:0] byteAddr;

    assign active = rdy && !ioBufferFull;
    assign byteAddr = req.addr + cpuMemPkg::ADDR_WIDTH'(stage);

    // newest byte enters at the top, earlier bytes move down
    assign assembled = {ramRdata, shiftWord[cpuMemPkg::XLEN-1:cpuMemPkg::BYTE_WIDTH]};

    // short loads sit in the upper bytes, shift them down and zero-fill
    assign dataRdata = assembled >> (cpuMemPkg::BYTE_WIDTH * (4 - req.len));
    assign fetchInst = assembled;

    always_comb begin
        // hold the last address so a stalled read returns the same byte
        ramCmd.we = 1'b0;
        ramCmd.addr = lastAddr;
        ramCmd.wdata = '0;
        dataDone = 1'b0;
        fetchDone = 1'b0;
        if (active) begin
            case (state)
                cpuMemPkg::stIdle: begin
                    if (dataEn) begin
                        ramCmd.addr = dataReq.addr;
                        if (dataReq.op == cpuMemPkg::opStore) begin
                            ramCmd.we = 1'b1;
                            ramCmd.wdata = dataReq.wdata[cpuMemPkg::BYTE_WIDTH-1:0];
                            dataDone = (dataReq.len == 3'd1);
                        end
                    end else if (fetchEn) begin
                        ramCmd.addr = fetchAddr;
                    end
                end
                cpuMemPkg::stLoad: begin
                    if (stage == req.len) begin
                        dataDone = 1'b1;
                    end else begin
                        ramCmd.addr = byteAddr;
                    end
                end
                cpuMemPkg::stFetch: begin
                    if (stage == 3'd4) begin
                        fetchDone = 1'b1;
                    end else begin
                        ramCmd.addr = byteAddr;
                    end
                end
                cpuMemPkg::stStore: begin
                    ramCmd.we = 1'b1;
                    ramCmd.addr = byteAddr;
                    ramCmd.wdata =
                        req.wdata[stage[1:0]*cpuMemPkg::BYTE_WIDTH +: cpuMemPkg::BYTE_WIDTH];
                    dataDone = (stage == req.len - 3'd1);
                end
                default: begin
                    ramCmd.we = 1'b0;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= cpuMemPkg::stIdle;
            stage <= '0;
            lastAddr <= '0;
        end else if (active) begin
            lastAddr <= ramCmd.addr;
            case (state)
                cpuMemPkg::stIdle: begin
                    // acceptance cycle already moved byte 0
                    stage <= 3'd1;
                    if (dataEn) begin
                        if (dataReq.op == cpuMemPkg::opLoad) begin
                            state <= cpuMemPkg::stLoad;
                        end else if (dataReq.len != 3'd1) begin
                            state <= cpuMemPkg::stStore;
                        end
                    end else if (fetchEn) begin
                        state <= cpuMemPkg::stFetch;
                    end
                end
                cpuMemPkg::stLoad: begin
                    if (stage == req.len) begin
                        state <= cpuMemPkg::stIdle;
                    end else begin
                        stage <= stage + 3'd1;
                    end
                end
                cpuMemPkg::stFetch: begin
                    if (stage == 3'd4) begin
                        state <= cpuMemPkg::stIdle;
                    end else begin
                        stage <= stage + 3'd1;
                    end
                end
                cpuMemPkg::stStore: begin
                    if (stage == req.len - 3'd1) begin
                        state <= cpuMemPkg::stIdle;
                    end else begin
                        stage <= stage + 3'd1;
                    end
                end
                default: begin
                    state <= cpuMemPkg::stIdle;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (active) begin
            if (state == cpuMemPkg::stIdle) begin
                if (dataEn) begin
                    req <= dataReq;
                end else if (fetchEn) begin
                    // a fetch is a four byte load
                    req.len <= 3'd4;
                    req.addr <= fetchAddr;
                end
            end else begin
                shiftWord <= assembled;
            end
        end
    end

endmodule

// ==== memSubsystem.sv ====
module memSubsystem (
    input  logic                                clk,
    input  logic                                rst,
    input  logic                                rdy,
    input  logic                                ioBufferFull,
    input  logic [cpuMemPkg::BYTE_WIDTH-1:0]    ramRdata,
    input  logic                                dataEn,
    input  cpuMemPkg::dataReq_t                 dataReq,
    input  logic                                popReady,
    output cpuMemPkg::memPort_t                 ramCmd,
    output logic                                dataDone,
    output logic [cpuMemPkg::XLEN-1:0]          dataRdata,
    output logic                                popValid,
    output cpuMemPkg::fetchEntry_t              popEntry
);

    logic fetchEn;
    logic [cpuMemPkg::ADDR_WIDTH-1:0] fetchAddr;
    logic fetchDone;
    logic [cpuMemPkg::XLEN-1:0] fetchInst;
    logic pushValid;
    cpuMemPkg::fetchEntry_t pushEntry;
    logic [2:0] queueFree;

    fetchUnit uFetch (
        .clk       (clk),
        .rst       (rst),
        .rdy       (rdy),
        .fetchDone (fetchDone),
        .fetchInst (fetchInst),
        .queueFree (queueFree),
        .fetchEn   (fetchEn),
        .fetchAddr (fetchAddr),
        .pushValid (pushValid),
        .pushEntry (pushEntry)
    );

    instQueue uQueue (
        .clk       (clk),
        .rst       (rst),
        .rdy       (rdy),
        .pushValid (pushValid),
        .pushEntry (pushEntry),
        .popReady  (popReady),
        .popValid  (popValid),
        .popEntry  (popEntry),
        .queueFree (queueFree)
    );

    memCtrl uCtrl (
        .clk          (clk),
        .rst          (rst),
        .rdy          (rdy),
        .ioBufferFull (ioBufferFull),
        .dataEn       (dataEn),
        .dataReq      (dataReq),
        .fetchEn      (fetchEn),
        .fetchAddr    (fetchAddr),
        .ramRdata     (ramRdata),
        .ramCmd       (ramCmd),
        .dataDone     (dataDone),
        .dataRdata    (dataRdata),
        .fetchDone    (fetchDone),
        .fetchInst    (fetchInst)
    );

endmodule

// ==== tbMemSubsystem.sv ====
module tbMemSubsystem;
    timeunit 1ns;
    timeprecision 1ps;

    typedef struct packed {
        cpuMemPkg::dataReq_t req;
        logic [7:0] pauseRdy;
        logic [7:0] pauseIo;
    } reqRow_t;

    localparam int NUM_REQ = 10;
    localparam int MAX_WAIT = 200;
    localparam int MIN_POPS = 16;

    logic clk;
    logic rst;
    logic rdy;
    logic ioBufferFull;
    logic [7:0] ramRdata;
    logic dataEn;
    cpuMemPkg::dataReq_t dataReq;
    logic popReady;
    cpuMemPkg::memPort_t ramCmd;
    logic dataDone;
    logic [31:0] dataRdata;
    logic popValid;
    cpuMemPkg::fetchEntry_t popEntry;

    logic [7:0] ram [256];
    reqRow_t reqTable [NUM_REQ];
    // long low stretch lets the queue fill up
    logic [63:0] popPattern = 64'hFFFF_FFFF_0000_000F;
    int seed = 45720;
    int popCycle;

    memSubsystem uut (.*);

    memChecker chk (
        .clk(clk), .rst(rst), .rdy(rdy), .ioBufferFull(ioBufferFull),
        .dataEn(dataEn), .dataReq(dataReq), .dataDone(dataDone), .dataRdata(dataRdata),
        .ramCmd(ramCmd), .popValid(popValid), .popReady(popReady), .popEntry(popEntry),
        .pushValid(uut.pushValid), .ctrlState(uut.uCtrl.state)
    );

    function automatic reqRow_t makeRow(cpuMemPkg::memOp_e op, int len, int addr,
                                        int wdata, int pr, int pi);
        reqRow_t r;
        r.req.op = op;
        r.req.len = 3'(len);
        r.req.addr = 32'(addr);
        r.req.wdata = 32'(wdata);
        r.pauseRdy = 8'(pr);
        r.pauseIo = 8'(pi);
        return r;
    endfunction

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // byte RAM with synchronous read
    always @(posedge clk) begin
        if (ramCmd.we) begin
            ram[ramCmd.addr[7:0]] <= ramCmd.wdata;
        end
        ramRdata <= ram[ramCmd.addr[7:0]];
    end

    initial begin
        popReady = 1'b0;
        popCycle = 0;
        @(negedge rst);
        forever begin
            @(posedge clk);
            #2;
            popReady = popPattern[popCycle % 64];
            popCycle++;
        end
    end

    initial begin
        int cyc;
        bit done;
        bit timedOut;
        for (int i = 0; i < 256; i++) begin
            ram[i] = 8'($random(seed));
        end
        ramRdata = '0;
        rst = 1'b1;
        rdy = 1'b1;
        ioBufferFull = 1'b0;
        dataEn = 1'b0;
        dataReq = '0;
        timedOut = 1'b0;
        reqTable[0] = makeRow(cpuMemPkg::opLoad, 1, 'h40, 0, 0, 0);
        reqTable[1] = makeRow(cpuMemPkg::opLoad, 2, 'h41, 0, 0, 0);
        reqTable[2] = makeRow(cpuMemPkg::opLoad, 4, 'h50, 0, 2, 0);
        reqTable[3] = makeRow(cpuMemPkg::opStore, 4, 'hC0, 'hA1B2C3D4, 0, 2);
        reqTable[4] = makeRow(cpuMemPkg::opLoad, 4, 'hC0, 0, 1, 1);
        reqTable[5] = makeRow(cpuMemPkg::opStore, 2, 'hC4, 'h55667788, 1, 0);
        reqTable[6] = makeRow(cpuMemPkg::opStore, 1, 'hC6, 'h99, 0, 0);
        reqTable[7] = makeRow(cpuMemPkg::opLoad, 4, 'hC4, 0, 0, 3);
        reqTable[8] = makeRow(cpuMemPkg::opLoad, 1, 'hC6, 0, 0, 0);
        reqTable[9] = makeRow(cpuMemPkg::opLoad, 2, 'h7E, 0, 2, 2);
        repeat (8) @(posedge clk);
        #2;
        rst = 1'b0;

        for (int i = 0; i < NUM_REQ && !timedOut; i++) begin
            repeat (3) @(posedge clk);
            #2;
            dataEn = 1'b1;
            dataReq = reqTable[i].req;
            cyc = 0;
            done = 1'b0;
            while (!done && cyc < MAX_WAIT) begin
                @(posedge clk);
                if (dataDone) begin
                    done = 1'b1;
                end else begin
                    #2;
                    // stall window opens one cycle into the request
                    rdy = !(cyc >= 1 && cyc < 1 + reqTable[i].pauseRdy);
                    ioBufferFull = (cyc >= 1 + reqTable[i].pauseRdy) &&
                        (cyc < 1 + reqTable[i].pauseRdy + reqTable[i].pauseIo);
                end
                cyc++;
            end
            #2;
            dataEn = 1'b0;
            rdy = 1'b1;
            ioBufferFull = 1'b0;
            if (!done) begin
                $display("timeout: request %0d never got dataDone", i);
                timedOut = 1'b1;
            end
        end

        cyc = 0;
        while (!timedOut && chk.popCount < MIN_POPS && cyc < MAX_WAIT) begin
            @(posedge clk);
            cyc++;
        end
        if (!timedOut && chk.popCount < MIN_POPS) begin
            $display("timeout: instruction queue stopped delivering entries");
        end
        chk.report();
        if (!timedOut && chk.errors == 0 && chk.popCount >= MIN_POPS) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule
